//--- rtl/soc_map_pkg.sv
package soc_map_pkg;

  // master request, one word per transfer
  typedef struct packed {
    logic [31:0] address;     // byte address
    logic        read;        // level, held until accepted
    logic        write;       // level, held until accepted
    logic [31:0] writedata;
    logic [3:0]  byteenable;  // one bit per byte lane
  } bus_req_t;

  // response of one slave, also the merged master response
  typedef struct packed {
    logic [31:0] readdata;
    logic        waitrequest;  // high stalls the master
  } slave_rsp_t;

  // one-hot region selects
  typedef struct packed {
    logic sram;
    logic vga_ctl;
    logic cache_ctl;
    logic keyb;
  } slave_sel_t;

  localparam int REGION_HI_W = 16;  // compared upper address half

  localparam logic [REGION_HI_W-1:0] SRAM_REGION  = 16'h0200;  // 0200_xxxx
  localparam logic [REGION_HI_W-1:0] VGA_REGION   = 16'h0204;  // display control
  localparam logic [REGION_HI_W-1:0] CACHE_REGION = 16'h0205;  // cache control
  localparam logic [REGION_HI_W-1:0] KEYB_REGION  = 16'h0206;  // ps/2 keyboard

  localparam int WORD_OFS_W = 14;  // address[15:2]

  // word offsets inside the control regions
  localparam logic [WORD_OFS_W-1:0] VGA_MODE_OFS    = 14'd0;
  localparam logic [WORD_OFS_W-1:0] VGA_BASE_OFS    = 14'd1;
  localparam logic [WORD_OFS_W-1:0] VGA_BLOCK_OFS   = 14'd2;
  localparam logic [WORD_OFS_W-1:0] CACHE_FLUSH_OFS = 14'd0;

endpackage

//--- rtl/periph_pkg.sv
package periph_pkg;

  localparam int PS2_FRAME_BITS  = 11;  // start, 8 data, parity, stop
  localparam int PS2_STORED_BITS = 10;  // stop bit dropped
  localparam int KEYB_PAD_W      = 32 - PS2_STORED_BITS - 1;

  // keyboard read word
  typedef struct packed {
    logic [KEYB_PAD_W-1:0]      pad;    // always zero
    logic                       valid;  // frame complete, clears on read
    logic [PS2_STORED_BITS-1:0] frame;  // bit 0 is the start bit
  } keyb_word_t;

  // control write word, decoded per addressed register
  typedef union packed {
    struct packed {
      logic [29:0] unused;
      logic [1:0]  mode;
    } vga_mode_v;
    struct packed {
      logic [15:0] unused;
      logic [15:0] base;   // display line base
    } line_base_v;
    struct packed {
      logic [30:0] unused;
      logic        block;
    } block_v;
    struct packed {
      logic        flush;  // bit 31
      logic [15:0] unused;
      logic [14:0] page;
    } flush_v;
  } ctrl_word_u;

  localparam logic [1:0] VGA_MODE_RESET = 2'd3;

endpackage

//--- rtl/bus_router.sv
`timescale 1ns/10ps

module bus_router (
  input  soc_map_pkg::bus_req_t   bus_req,
  input  soc_map_pkg::slave_rsp_t sram_rsp,
  input  soc_map_pkg::slave_rsp_t keyb_rsp,
  output soc_map_pkg::slave_sel_t sel,
  output soc_map_pkg::slave_rsp_t bus_rsp
);
  import soc_map_pkg::*;

  logic [REGION_HI_W-1:0] region;  // upper address half

  assign region = bus_req.address[31:32-REGION_HI_W];

  // region decode, selects are independent of read/write
  always_comb begin
    sel           = '0;
    sel.sram      = (region == SRAM_REGION);
    sel.vga_ctl   = (region == VGA_REGION);
    sel.cache_ctl = (region == CACHE_REGION);
    sel.keyb      = (region == KEYB_REGION);
  end

  // response mux, sram has priority
  always_comb begin
    if (sel.sram) begin
      bus_rsp = sram_rsp;
    end else if (sel.keyb) begin
      bus_rsp = keyb_rsp;
    end else begin
      bus_rsp = '0;  // control, unmapped: zero data, no wait
    end
  end

  // region constants must stay distinct
  always_comb begin
    assert ($onehot0(sel))
      else $error("bus_router: more than one select for %h", bus_req.address);
  end

endmodule

//--- rtl/sram_bank.sv
`timescale 1ns/10ps

module sram_bank #(
  parameter int SRAM_AW = 9  // word address width
) (
  input  logic                    clk,
  input  logic                    reset_n,
  input  soc_map_pkg::bus_req_t   bus_req,
  input  logic                    sel_sram,
  output soc_map_pkg::slave_rsp_t rsp
);

  logic [31:0]        mem [2**SRAM_AW];
  logic [SRAM_AW-1:0] word_addr;
  logic [31:0]        rd_data;   // registered array output
  logic               rd_req;
  logic               wr_req;
  logic               read_ack;  // second read cycle

  assign word_addr = bus_req.address[SRAM_AW+1:2];  // byte address to word
  assign rd_req    = sel_sram & bus_req.read;
  assign wr_req    = sel_sram & bus_req.write;

  // byte-lane writes, unenabled lanes keep old data
  always_ff @(posedge clk) begin
    if (wr_req) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (bus_req.byteenable[lane]) begin
          mem[word_addr][8*lane +: 8] <= bus_req.writedata[8*lane +: 8];
        end
      end
    end
    rd_data <= mem[word_addr];  // ready when read_ack rises
  end

  // one wait state per read
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      read_ack <= 1'b0;
    end else if (rd_req && !read_ack) begin
      read_ack <= 1'b1;
    end else if (!rd_req && read_ack) begin
      read_ack <= 1'b0;  // needs an idle cycle before next read
    end
  end

  assign rsp.readdata    = rd_data;
  assign rsp.waitrequest = rd_req & ~read_ack;

  // a held read is stalled for one cycle only
  wait_single_a: assert property (@(posedge clk) disable iff (!reset_n)
    rsp.waitrequest |=> !rsp.waitrequest)
    else $error("sram_bank: waitrequest high two cycles in a row");

endmodule

//--- rtl/ctrl_regs.sv
`timescale 1ns/10ps

module ctrl_regs (
  input  logic                  clk,
  input  logic                  reset_n,
  input  soc_map_pkg::bus_req_t bus_req,
  input  logic                  sel_vga,
  input  logic                  sel_cache,
  output logic [1:0]            vga_mode,
  output logic [15:0]           line_base,
  output logic                  block_vga,
  output logic                  flush_cache,
  output logic [14:0]           flush_page
);
  import soc_map_pkg::*;
  import periph_pkg::*;

  ctrl_word_u            wr_word;   // writedata viewed per register
  logic [WORD_OFS_W-1:0] word_ofs;  // address[15:2]
  logic                  vga_wr;
  logic                  cache_wr;
  logic                  reg_wr;    // write to a defined register

  assign wr_word  = bus_req.writedata;
  assign word_ofs = bus_req.address[WORD_OFS_W+1:2];
  assign vga_wr   = sel_vga & bus_req.write;
  assign cache_wr = sel_cache & bus_req.write;
  assign reg_wr   = (vga_wr && word_ofs inside {VGA_MODE_OFS, VGA_BASE_OFS, VGA_BLOCK_OFS})
                    || (cache_wr && word_ofs == CACHE_FLUSH_OFS);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      vga_mode    <= VGA_MODE_RESET;
      line_base   <= '0;
      block_vga   <= 1'b0;
      flush_cache <= 1'b0;
      flush_page  <= '0;
    end else begin
      if (vga_wr) begin
        case (word_ofs)
          VGA_MODE_OFS:  vga_mode  <= wr_word.vga_mode_v.mode;
          VGA_BASE_OFS:  line_base <= wr_word.line_base_v.base;
          VGA_BLOCK_OFS: block_vga <= wr_word.block_v.block;
          default: ;  // other offsets ignored
        endcase
      end
      if (cache_wr && word_ofs == CACHE_FLUSH_OFS) begin
        flush_cache <= wr_word.flush_v.flush;  // level held for the cache side
        flush_page  <= wr_word.flush_v.page;
      end
    end
  end

  // outputs move only on a register write
  ctrl_hold_a: assert property (@(posedge clk) disable iff (!reset_n)
    !reg_wr |=> $stable({vga_mode, line_base, block_vga, flush_cache, flush_page}))
    else $error("ctrl_regs: output changed without a write");

endmodule

//--- rtl/ps2_keyb_rx.sv
`timescale 1ns/10ps

module ps2_keyb_rx #(
  parameter int KEYB_TIMEOUT_W = 16  // idle counter width
) (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    key_clk,
  input  logic                    key_data,
  input  soc_map_pkg::bus_req_t   bus_req,
  input  logic                    sel_keyb,
  output soc_map_pkg::slave_rsp_t rsp,
  output logic                    key_valid
);
  import periph_pkg::*;

  logic [1:0]                 kclk_sync;  // [0] first flop, [1] second
  logic                       kclk_fall;
  logic [KEYB_TIMEOUT_W-1:0]  idle_cnt;
  logic                       idle_full;  // line idle, next edge is a start bit
  logic [3:0]                 bit_idx;
  logic [PS2_STORED_BITS-1:0] frame;
  logic                       rd_req;
  keyb_word_t                 rd_word;

  assign kclk_fall = kclk_sync[1] & ~kclk_sync[0];
  assign idle_full = &idle_cnt;
  assign rd_req    = sel_keyb & bus_req.read;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      kclk_sync <= '0;
      idle_cnt  <= '0;
      bit_idx   <= '0;
      key_valid <= 1'b0;
    end else begin
      kclk_sync <= {kclk_sync[0], key_clk};
      if (kclk_fall) begin
        idle_cnt <= '0;
        if (idle_full) begin
          bit_idx <= 4'd1;  // resync, this edge was bit 0
        end else if (bit_idx == 4'(PS2_FRAME_BITS - 1)) begin
          bit_idx   <= '0;  // stop bit, frame done
          key_valid <= 1'b1;
        end else begin
          bit_idx <= bit_idx + 4'd1;
        end
      end else if (!idle_full) begin
        idle_cnt <= idle_cnt + 1'b1;  // saturates
      end
      if (rd_req) begin
        key_valid <= 1'b0;  // read wins over a completing frame
      end
    end
  end

  // frame bits, stop bit sampled but not kept
  always_ff @(posedge clk) begin
    if (kclk_fall) begin
      if (idle_full) begin
        frame[0] <= key_data;
      end else if (bit_idx < 4'(PS2_STORED_BITS)) begin
        frame[bit_idx] <= key_data;
      end
    end
  end

  always_comb begin
    rd_word       = '0;
    rd_word.valid = key_valid;  // value before the clear
    rd_word.frame = frame;
  end

  assign rsp.readdata    = rd_word;
  assign rsp.waitrequest = 1'b0;

endmodule

//--- rtl/periph_bus.sv
`timescale 1ns/10ps

module periph_bus #(
  parameter int SRAM_AW        = 9,
  parameter int KEYB_TIMEOUT_W = 16
) (
  input  logic                    clk,
  input  logic                    reset_n,
  input  soc_map_pkg::bus_req_t   bus_req,
  output soc_map_pkg::slave_rsp_t bus_rsp,
  input  logic                    key_clk,
  input  logic                    key_data,
  output logic [1:0]              vga_mode,
  output logic [15:0]             line_base,
  output logic                    block_vga,
  output logic                    flush_cache,
  output logic [14:0]             flush_page,
  output logic                    key_valid
);
  import soc_map_pkg::*;

  slave_sel_t sel;
  slave_rsp_t sram_rsp;
  slave_rsp_t keyb_rsp;

  bus_router u_bus_router (
    .bus_req  (bus_req),
    .sram_rsp (sram_rsp),
    .keyb_rsp (keyb_rsp),
    .sel      (sel),
    .bus_rsp  (bus_rsp)
  );

  sram_bank #(
    .SRAM_AW (SRAM_AW)
  ) u_sram_bank (
    .clk      (clk),
    .reset_n  (reset_n),
    .bus_req  (bus_req),
    .sel_sram (sel.sram),
    .rsp      (sram_rsp)
  );

  ctrl_regs u_ctrl_regs (
    .clk         (clk),
    .reset_n     (reset_n),
    .bus_req     (bus_req),
    .sel_vga     (sel.vga_ctl),
    .sel_cache   (sel.cache_ctl),
    .vga_mode    (vga_mode),
    .line_base   (line_base),
    .block_vga   (block_vga),
    .flush_cache (flush_cache),
    .flush_page  (flush_page)
  );

  ps2_keyb_rx #(
    .KEYB_TIMEOUT_W (KEYB_TIMEOUT_W)
  ) u_ps2_keyb_rx (
    .clk       (clk),
    .reset_n   (reset_n),
    .key_clk   (key_clk),
    .key_data  (key_data),
    .bus_req   (bus_req),
    .sel_keyb  (sel.keyb),
    .rsp       (keyb_rsp),
    .key_valid (key_valid)
  );

endmodule

//--- sim/periph_bus_tb.sv
`timescale 1ns/10ps

module periph_bus_tb;
  import soc_map_pkg::*;

  localparam int BIT_CYCLES = 12;  // one ps/2 bit time in clk cycles
  localparam int RUN_CYCLES = 8 + 8 * 12 + 40 + 2 * (11 * BIT_CYCLES + 30)
                              + 4 * BIT_CYCLES + 300 + 20;

  typedef struct packed {
    logic [1:0]  mode;
    logic [15:0] base;
    logic        block;
    logic        flush;
    logic [14:0] page;
  } ctrl_out_t;

  logic        clk = 1'b0;
  logic        reset_n = 1'b0;
  bus_req_t    bus_req = '0;
  slave_rsp_t  bus_rsp;
  logic        key_clk = 1'b1;   // ps/2 lines idle high
  logic        key_data = 1'b1;
  logic [1:0]  vga_mode;
  logic [15:0] line_base;
  logic        block_vga;
  logic        flush_cache;
  logic [14:0] flush_page;
  logic        key_valid;
  ctrl_out_t   ctrl_model = {2'd3, 33'd0};  // expected control outputs
  int          seed = 32'h720b3a97;
  int          errors = 0;
  int          tests = 0;
  logic [15:0] region;
  logic        sram_rd;

  assign region  = bus_req.address[31:16];
  assign sram_rd = bus_req.read && region == 16'h0200;

  always #4 clk = ~clk;

  periph_bus #(.KEYB_TIMEOUT_W(8)) u_periph_bus (
    .clk(clk), .reset_n(reset_n), .bus_req(bus_req), .bus_rsp(bus_rsp),
    .key_clk(key_clk), .key_data(key_data), .vga_mode(vga_mode),
    .line_base(line_base), .block_vga(block_vga), .flush_cache(flush_cache),
    .flush_page(flush_page), .key_valid(key_valid)
  );

  function automatic void note_failure(input string what);
    errors++;
    $display("%s", what);
  endfunction

  sram_wait_a: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(sram_rd) |-> bus_rsp.waitrequest ##1 !bus_rsp.waitrequest)
    else note_failure("sram read did not stall for exactly one cycle");
  no_wait_a: assert property (@(posedge clk) disable iff (!reset_n)
    (bus_req.read || bus_req.write) && !sram_rd |-> !bus_rsp.waitrequest)
    else note_failure("waitrequest raised on a transfer that never waits");
  zero_read_a: assert property (@(posedge clk) disable iff (!reset_n)
    bus_req.read && region != 16'h0200 && region != 16'h0206 |-> bus_rsp.readdata == 0)
    else note_failure("control or unmapped read returned nonzero data");
  keyb_clear_a: assert property (@(posedge clk) disable iff (!reset_n)
    bus_req.read && region == 16'h0206 |=> !key_valid)
    else note_failure("key_valid still set after a keyboard read");
  ctrl_model_a: assert property (@(posedge clk) disable iff (!reset_n)
    {vga_mode, line_base, block_vga, flush_cache, flush_page} == ctrl_model)
    else note_failure("control outputs differ from the register model");

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected)
      else note_failure($sformatf("ERROR %s: expected %0h, actual %0h", name, expected, actual));
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %s done, errors so far %0d", name, errors);
  endtask

  // called 1 ns after a rising edge, returns at the same phase
  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] be);
    bus_req.address    = addr;
    bus_req.writedata  = data;
    bus_req.byteenable = be;
    bus_req.write      = 1'b1;
    @(negedge clk);
    while (bus_rsp.waitrequest) @(negedge clk);
    @(posedge clk);
    #1;
    bus_req.write = 1'b0;
    case ({addr[31:16], addr[15:2]})  // register model, updated after the write edge
      {16'h0204, 14'd0}: ctrl_model.mode = data[1:0];
      {16'h0204, 14'd1}: ctrl_model.base = data[15:0];
      {16'h0204, 14'd2}: ctrl_model.block = data[0];
      {16'h0205, 14'd0}: begin
        ctrl_model.flush = data[31];
        ctrl_model.page  = data[14:0];
      end
      default: ;  // unused offsets hold
    endcase
  endtask

  task automatic read_word(input logic [31:0] addr, output logic [31:0] data,
                           output int waits);
    bus_req.address = addr;
    bus_req.read    = 1'b1;
    waits           = 0;
    @(negedge clk);
    while (bus_rsp.waitrequest) begin
      waits++;
      @(negedge clk);
    end
    data = bus_rsp.readdata;  // accepting cycle
    @(posedge clk);
    #1;
    bus_req.read = 1'b0;
    @(posedge clk);  // idle cycle so the sram ack clears
    #1;
  endtask

  // start 0, data lsb first, odd parity, stop 1
  function automatic logic [10:0] make_frame(input logic [7:0] data);
    return {1'b1, ~^data, data, 1'b0};
  endfunction

  task automatic send_ps2_bits(input logic [10:0] bits, input int count);
    for (int i = 0; i < count; i++) begin
      key_data = bits[i];
      repeat (3) @(posedge clk);
      #1 key_clk = 1'b0;  // receiver samples on this fall
      repeat (6) @(posedge clk);
      #1 key_clk = 1'b1;
      repeat (3) @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_key_valid();
    int cycles;
    cycles = 0;
    while (!key_valid && cycles < 20) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!key_valid) note_failure("key_valid did not rise after a full frame");
  endtask

  initial begin
    #(2 * RUN_CYCLES * 8);  // twice the summed test length
    $display("watchdog expired before the tests finished");
    $display("Finished with errors");
    $finish;
  end

  initial begin
    logic [31:0] rdata;
    logic [31:0] addr;
    logic [31:0] old_word;
    logic [31:0] new_word;
    logic [31:0] expected;
    logic [3:0]  be;
    logic [10:0] frame;
    int          waits;
    repeat (8) @(posedge clk);
    #1 reset_n = 1'b1;
    check_value("reset_outputs", {27'd0, 2'd3, 35'd0}, {27'd0, vga_mode, line_base,
                block_vga, flush_cache, flush_page, key_valid, bus_rsp.waitrequest});
    end_test("reset");

    for (int i = 0; i < 8; i++) begin
      addr     = 32'h0200_0000 | ((32'($random(seed)) & 32'h1ff) << 2);  // 512 words
      old_word = $random(seed);
      new_word = $random(seed);
      be       = 4'($random(seed));
      write_word(addr, old_word, 4'hf);
      write_word(addr, new_word, be);
      expected = old_word;
      for (int lane = 0; lane < 4; lane++) begin
        if (be[lane]) expected[8*lane +: 8] = new_word[8*lane +: 8];
      end
      read_word(addr, rdata, waits);
      check_value("sram_data", expected, rdata);
      check_value("sram_waits", 1, waits);
    end
    end_test("sram");

    write_word(32'h0204_0000, $random(seed), 4'hf);  // mode
    write_word(32'h0204_0004, $random(seed), 4'hf);  // line base
    write_word(32'h0204_0008, 32'h1, 4'hf);          // block
    write_word(32'h0205_0000, 32'h8000_0000 | $random(seed), 4'hf);
    write_word(32'h0204_000c, 32'hffff_ffff, 4'hf);  // unused offsets
    write_word(32'h0205_0004, 32'h0000_0000, 4'hf);
    check_value("ctrl_outputs", ctrl_model,
                {vga_mode, line_base, block_vga, flush_cache, flush_page});
    read_word(32'h0204_0004, rdata, waits);
    check_value("vga_read", 0, rdata);
    read_word(32'h0205_0000, rdata, waits);
    check_value("cache_read", 0, rdata);
    end_test("ctrl_regs");

    frame = make_frame(8'($random(seed)));
    send_ps2_bits(frame, 11);
    wait_key_valid();
    read_word(32'h0206_0000, rdata, waits);
    check_value("keyb_word", {21'd0, 1'b1, frame[9:0]}, rdata);
    check_value("keyb_valid_cleared", 0, key_valid);
    end_test("keyb_frame");

    send_ps2_bits(11'h4b6, 4);  // broken-off frame
    repeat (300) @(posedge clk);  // longer than the full idle count
    #1;
    frame = make_frame(8'($random(seed)));
    send_ps2_bits(frame, 11);
    wait_key_valid();
    read_word(32'h0206_0000, rdata, waits);
    check_value("keyb_resync_word", {21'd0, 1'b1, frame[9:0]}, rdata);
    end_test("keyb_resync");

    read_word(32'h1000_0000, rdata, waits);
    check_value("unmapped_data", 0, rdata);
    check_value("unmapped_waits", 0, waits);
    end_test("unmapped");

    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- periph_bus.f
rtl/soc_map_pkg.sv
rtl/periph_pkg.sv
rtl/bus_router.sv
rtl/sram_bank.sv
rtl/ctrl_regs.sv
rtl/ps2_keyb_rx.sv
rtl/periph_bus.sv
sim/periph_bus_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = periph_bus_tb
FILELIST = periph_bus.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Finished with errors
PASS_MSG = Finished with no errors

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
